/* hw/packer_settings.svh */
`ifndef PACKER_SETTINGS_SVH
`define PACKER_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths and store size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CODE_WIDTH     128
`define CODE_LEN_WIDTH 7
`define ACC_WIDTH      256
`define WORD_WIDTH     32
`define STORE_DEPTH    16
`define READY_LIMIT    64   // Leaves room for a 224-bit append on top of 31 held bits

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed header patterns, oldest bit in the MSB
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SLICE_HDR_BITS {32'h0000_0001, 43'b0110010110001000100000000010000000000001111}
`define SLICE_HDR_LEN  75
`define MB_HDR_BITS    22'b1111111111111111110111
`define MB_HDR_LEN     22

`endif

/* hw/packer_code_pkg.sv */
`default_nettype none

`include "packer_settings.svh"

package packer_code_pkg;

    // A variable-length code from the CAVLC coder, right-aligned
    typedef logic [`CODE_WIDTH-1:0] code_bits_t;

    typedef logic [`CODE_LEN_WIDTH-1:0] code_len_t;

    // Headers plus code, right-aligned, same width as the accumulator
    typedef logic [`ACC_WIDTH-1:0] frag_bits_t;

    // Counts 0 to ACC_WIDTH inclusive
    typedef logic [$clog2(`ACC_WIDTH+1)-1:0] acc_len_t;

endpackage : packer_code_pkg

`default_nettype wire

/* hw/packer_store_pkg.sv */
`default_nettype none

`include "packer_settings.svh"

package packer_store_pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [31:0] waddr_t;                          // Free-running, wraps at 2^32
    typedef logic [$clog2(`STORE_DEPTH)-1:0] store_idx_t;

endpackage : packer_store_pkg

`default_nettype wire

/* hw/header_inserter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "packer_settings.svh"

module header_inserter (
    input  wire packer_code_pkg::code_bits_t code_bits,
    input  wire packer_code_pkg::code_len_t  code_len,
    input  wire                              slice_header_en,
    input  wire                              mb_header_en,
    output packer_code_pkg::frag_bits_t      frag_bits,
    output packer_code_pkg::acc_len_t        frag_len
);

    packer_code_pkg::frag_bits_t code_ext;
    packer_code_pkg::frag_bits_t code_mask;
    packer_code_pkg::frag_bits_t with_mb;
    packer_code_pkg::acc_len_t   len_code;
    packer_code_pkg::acc_len_t   len_mb;

    assign len_code = packer_code_pkg::acc_len_t'(code_len);

    // Bits above code_len are not guaranteed clean by the coder
    assign code_mask = ~({`ACC_WIDTH{1'b1}} << len_code);
    assign code_ext  = packer_code_pkg::frag_bits_t'(code_bits) & code_mask;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prepend headers, youngest first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        with_mb = code_ext;
        len_mb  = len_code;
        if (mb_header_en) begin
            with_mb = code_ext | (packer_code_pkg::frag_bits_t'(`MB_HDR_BITS) << len_code);
            len_mb  = len_code + packer_code_pkg::acc_len_t'(`MB_HDR_LEN);
        end
    end

    always_comb begin
        frag_bits = with_mb;
        frag_len  = len_mb;
        if (slice_header_en) begin    // Slice header lands in the oldest bits
            frag_bits = with_mb | (packer_code_pkg::frag_bits_t'(`SLICE_HDR_BITS) << len_mb);
            frag_len  = len_mb + packer_code_pkg::acc_len_t'(`SLICE_HDR_LEN);
        end
    end

endmodule : header_inserter

`default_nettype wire

/* hw/bit_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "packer_settings.svh"

module bit_accumulator (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              frag_valid,
    input  wire packer_code_pkg::frag_bits_t frag_bits,
    input  wire packer_code_pkg::acc_len_t   frag_len,
    output logic                             word_valid,
    output packer_store_pkg::word_t          word,
    output logic                             packer_ready
);

    // Pending bits sit right-aligned, oldest bit at acc_len-1
    packer_code_pkg::frag_bits_t acc_bits;
    packer_code_pkg::acc_len_t   acc_len;

    packer_code_pkg::acc_len_t   rem_len;
    packer_code_pkg::frag_bits_t rem_bits;
    packer_code_pkg::frag_bits_t next_bits;
    packer_code_pkg::acc_len_t   next_len;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word extraction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign word_valid = (acc_len >= packer_code_pkg::acc_len_t'(`WORD_WIDTH));

    always_comb begin
        if (word_valid) begin
            word = packer_store_pkg::word_t'(acc_bits >> (acc_len - `WORD_WIDTH));
        end else begin
            word = '0;
        end
    end

    // Whatever stays behind after this cycle's word leaves
    assign rem_len = word_valid ? acc_len - packer_code_pkg::acc_len_t'(`WORD_WIDTH)
                                : acc_len;

    // Clear the emitted and stale bits so the shift below stays clean
    assign rem_bits = acc_bits & ~({`ACC_WIDTH{1'b1}} << rem_len);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Append the arriving fragment
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_bits = rem_bits;
        next_len  = rem_len;
        if (frag_valid) begin
            // With ready honoured rem_len is at most 31, so 31 + 224 fits
            next_bits = (rem_bits << frag_len) | frag_bits;
            next_len  = rem_len + frag_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_len      <= '0;
            packer_ready <= 1'b1;
        end else begin
            acc_len      <= next_len;
            packer_ready <= (next_len < packer_code_pkg::acc_len_t'(`READY_LIMIT));
        end
    end

    always_ff @(posedge clk) begin
        acc_bits <= next_bits;
    end

endmodule : bit_accumulator

`default_nettype wire

/* hw/word_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "packer_settings.svh"

module word_store (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               word_valid,
    input  wire packer_store_pkg::word_t      word,
    input  wire packer_store_pkg::store_idx_t rd_addr,
    output packer_store_pkg::waddr_t          waddr,
    output packer_store_pkg::word_t           rd_data
);

    packer_store_pkg::word_t mem [`STORE_DEPTH];

    packer_store_pkg::store_idx_t wr_idx;

    // Circular store, low bits of the running counter pick the slot
    assign wr_idx = packer_store_pkg::store_idx_t'(waddr);

    always_ff @(posedge clk) begin
        if (rst) begin
            waddr <= '0;
            for (int i = 0; i < `STORE_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (word_valid) begin
            mem[wr_idx] <= word;
            waddr       <= waddr + 32'd1;
        end
    end

    // The next stage reads asynchronously
    assign rd_data = mem[rd_addr];

endmodule : word_store

`default_nettype wire

/* hw/packer_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "packer_settings.svh"

module packer_top (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               code_valid,
    input  wire packer_code_pkg::code_bits_t  code_bits,
    input  wire packer_code_pkg::code_len_t   code_len,
    input  wire                               slice_header_en,
    input  wire                               mb_header_en,
    input  wire packer_store_pkg::store_idx_t rd_addr,
    output logic                              packer_ready,
    output packer_store_pkg::waddr_t          waddr,
    output packer_store_pkg::word_t           rd_data
);

    packer_code_pkg::frag_bits_t frag_bits;
    packer_code_pkg::acc_len_t   frag_len;

    logic                        word_valid;
    packer_store_pkg::word_t     word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Header splice, then packing, then storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    header_inserter header_inserter_inst (
        .code_bits       (code_bits),
        .code_len        (code_len),
        .slice_header_en (slice_header_en),
        .mb_header_en    (mb_header_en),
        .frag_bits       (frag_bits),
        .frag_len        (frag_len)
    );

    // The inserter is combinational, so the code strobe is the fragment strobe
    bit_accumulator bit_accumulator_inst (
        .clk          (clk),
        .rst          (rst),
        .frag_valid   (code_valid),
        .frag_bits    (frag_bits),
        .frag_len     (frag_len),
        .word_valid   (word_valid),
        .word         (word),
        .packer_ready (packer_ready)
    );

    word_store word_store_inst (
        .clk        (clk),
        .rst        (rst),
        .word_valid (word_valid),
        .word       (word),
        .rd_addr    (rd_addr),
        .waddr      (waddr),
        .rd_data    (rd_data)
    );

endmodule : packer_top

`default_nettype wire

/* testbench/packer_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "packer_settings.svh"

module packer_properties #(
    parameter bit ACC_SIDE = 1'b1
) (
    input wire                            clk,
    input wire                            rst,
    input wire                            frag_valid,
    input wire                            packer_ready,
    input wire packer_code_pkg::acc_len_t acc_len,
    input wire packer_code_pkg::acc_len_t frag_len,
    input wire                            word_valid,
    input wire packer_store_pkg::waddr_t  waddr
);

    int fail_count = 0;    // Number of failed checks in this copy
    int appended_len;

    // Length after this cycle's word leaves and the fragment lands
    assign appended_len = ((int'(acc_len) >= `WORD_WIDTH) ? int'(acc_len) - `WORD_WIDTH
                                                          : int'(acc_len)) + int'(frag_len);

    if (ACC_SIDE) begin : g_acc_checks
        ready_honoured: assert property (@(posedge clk) disable iff (rst)
            frag_valid |-> packer_ready)
            else begin
                fail_count++;
                $error("A fragment was offered while packer_ready was low");
            end

        length_bounded: assert property (@(posedge clk) disable iff (rst)
            (int'(acc_len) <= `ACC_WIDTH) && (!frag_valid || appended_len <= `ACC_WIDTH))
            else begin
                fail_count++;
                $error("The accumulator would hold more than %0d bits", `ACC_WIDTH);
            end
    end else begin : g_store_checks
        waddr_steps: assert property (@(posedge clk) disable iff (rst)
            waddr == ($past(word_valid) ? $past(waddr) + 32'd1 : $past(waddr)))
            else begin
                fail_count++;
                $error("waddr did not move by exactly one per emitted word");
            end
    end

endmodule : packer_properties

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Attachment
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
bind bit_accumulator packer_properties #(.ACC_SIDE(1'b1)) acc_props_inst (
    .clk          (clk),
    .rst          (rst),
    .frag_valid   (frag_valid),
    .packer_ready (packer_ready),
    .acc_len      (acc_len),
    .frag_len     (frag_len),
    .word_valid   (1'b0),     // Store counter is checked in the other copy
    .waddr        (32'd0)
);

bind word_store packer_properties #(.ACC_SIDE(1'b0)) store_props_inst (
    .clk          (clk),
    .rst          (rst),
    .frag_valid   (1'b0),     // Only the store-side signals are live here
    .packer_ready (1'b1),
    .acc_len      (9'd0),
    .frag_len     (9'd0),
    .word_valid   (word_valid),
    .waddr        (waddr)
);

`default_nettype wire

/* testbench/packer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "packer_settings.svh"

module packer_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int PLAIN_CODES     = 60;
    localparam int HEADER_CODES    = 40;
    localparam int BURST_CODES     = 24;
    localparam int NUM_CODES       = PLAIN_CODES + HEADER_CODES + BURST_CODES;
    localparam int WATCHDOG_CYCLES = NUM_CODES * 4 + 200;

    logic                         clk = 1'b0;
    logic                         rst = 1'b1;
    logic                         code_valid = 1'b0;
    packer_code_pkg::code_bits_t  code_bits = '0;
    packer_code_pkg::code_len_t   code_len = '0;
    logic                         slice_header_en = 1'b0;
    logic                         mb_header_en = 1'b0;
    packer_store_pkg::store_idx_t rd_addr = '0;
    logic                         packer_ready;
    packer_store_pkg::waddr_t     waddr;
    packer_store_pkg::word_t      rd_data;

    logic [31:0]              lfsr_state = 32'h5a8726da;
    logic                     exp_q[$];    // Expected bitstream, oldest bit at the front
    int                       total_bits = 0;
    int                       readback_errors = 0;
    int                       words_checked = 0;
    int                       ready_waits = 0;
    packer_store_pkg::waddr_t seen_waddr = '0;
    logic                     check_pending = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    packer_top packer_top_inst (
        .clk             (clk),
        .rst             (rst),
        .code_valid      (code_valid),
        .code_bits       (code_bits),
        .code_len        (code_len),
        .slice_header_en (slice_header_en),
        .mb_header_en    (mb_header_en),
        .rd_addr         (rd_addr),
        .packer_ready    (packer_ready),
        .waddr           (waddr),
        .rd_data         (rd_data)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] take_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[126:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic packer_store_pkg::word_t pop_word();
        packer_store_pkg::word_t w;
        w = '0;
        for (int i = 0; i < `WORD_WIDTH; i++) begin
            w = {w[30:0], exp_q.pop_front()};    // First bit out lands in bit 31
        end
        return w;
    endfunction

    task automatic push_bits(input logic [127:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            exp_q.push_back(v[i]);
        end
        total_bits += n;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One clock edge plus the read-back pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        packer_store_pkg::word_t expected;
        @(posedge clk);
        if (check_pending) begin
            assert (exp_q.size() >= `WORD_WIDTH) else begin
                readback_errors++;
                $display("The store wrote a word before 32 bits had been offered");
            end
            expected = pop_word();
            words_checked++;
            assert (rd_data == expected) else begin
                readback_errors++;
                $display("Error at %0t ns: word %0d reads %h, expected %h",
                         $time, seen_waddr - 32'd1, rd_data, expected);
            end
        end
        check_pending = !rst && (waddr != seen_waddr);
        if (check_pending) begin
            seen_waddr = waddr;
            rd_addr <= packer_store_pkg::store_idx_t'(waddr - 32'd1);    // Newest word
        end
        assert (waddr <= total_bits / `WORD_WIDTH) else begin
            readback_errors++;
            $display("Error at %0t ns: waddr %0d is ahead of %0d offered bits",
                     $time, waddr, total_bits);
        end
    endtask

    task automatic check_reset_state();
        assert (packer_ready && waddr == '0) else begin
            readback_errors++;
            $display("Error at %0t ns: ready %b waddr %0d after reset",
                     $time, packer_ready, waddr);
        end
        for (int i = 0; i < `STORE_DEPTH; i++) begin
            rd_addr <= packer_store_pkg::store_idx_t'(i);
            next_cycle();
            assert (rd_data == '0) else begin
                readback_errors++;
                $display("Error at %0t ns: store index %0d holds %h after reset",
                         $time, i, rd_data);
            end
        end
    endtask

    // The idle cycle after each code lets packer_ready catch up before the next one
    task automatic send_code(input logic slice_en, input logic mb_en, input int len);
        logic [127:0] v;
        v = take_bits(128);    // Bits above len are junk the inserter must drop
        while (!packer_ready) begin
            ready_waits++;
            next_cycle();
        end
        code_valid      <= 1'b1;
        code_bits       <= v;
        code_len        <= packer_code_pkg::code_len_t'(len);
        slice_header_en <= slice_en;
        mb_header_en    <= mb_en;
        if (slice_en) begin
            push_bits(128'(`SLICE_HDR_BITS), `SLICE_HDR_LEN);
        end
        if (mb_en) begin
            push_bits(128'(`MB_HDR_BITS), `MB_HDR_LEN);
        end
        push_bits(v, len);
        next_cycle();
        code_valid <= 1'b0;
        next_cycle();
    endtask

    task automatic drain_and_check();
        int guard;
        guard = 0;
        while (waddr != total_bits / `WORD_WIDTH && guard < 16) begin
            next_cycle();
            guard++;
        end
        next_cycle();
        next_cycle();
        assert (waddr == total_bits / `WORD_WIDTH) else begin
            readback_errors++;
            $display("Error at %0t ns: waddr %0d after draining %0d bits",
                     $time, waddr, total_bits);
        end
    endtask

    initial begin
        int         len;
        logic [1:0] sel;
        int         prop_failures;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        next_cycle();
        check_reset_state();

        for (int i = 0; i < PLAIN_CODES; i++) begin
            len = int'(take_bits(7));
            if (len == 0) begin
                len = 1;
            end
            send_code(1'b0, 1'b0, len);
        end
        drain_and_check();

        for (int i = 0; i < HEADER_CODES; i++) begin
            sel = 2'(take_bits(2));
            len = int'(take_bits(7));
            if (len == 0) begin
                len = 1;
            end
            send_code(sel[1], sel[0], len);
        end
        drain_and_check();

        ready_waits = 0;
        for (int i = 0; i < BURST_CODES; i++) begin
            send_code(1'b1, 1'b1, 127);    // 224 bits each, faster than the store drains
        end
        drain_and_check();
        assert (ready_waits > 0) else begin
            readback_errors++;
            $display("packer_ready never dropped during the header bursts");
        end

        prop_failures = packer_top_inst.bit_accumulator_inst.acc_props_inst.fail_count
                      + packer_top_inst.word_store_inst.store_props_inst.fail_count;
        $display("Words checked: %0d, read-back errors: %0d, assertion failures: %0d",
                 words_checked, readback_errors, prop_failures);
        if (readback_errors == 0 && prop_failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule : packer_tb

`default_nettype wire

/* sources.f */
+incdir+hw
hw/packer_code_pkg.sv
hw/packer_store_pkg.sv
hw/header_inserter.sv
hw/bit_accumulator.sv
hw/word_store.sv
hw/packer_top.sv
testbench/packer_properties.sv
testbench/packer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the packer testbench with Verilator, runs it and looks for the pass line.
# The error limit lets the run reach its closing report after a bound assertion fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module packer_tb -o packer_sim &&
./obj_dir/packer_sim +verilator+error+limit+1000 | tee /dev/stderr |
    grep -x "all tests passed" > /dev/null &&
echo "Simulation run: PASS" ||
{ echo "Simulation run: FAIL"; exit 1; }
